//--- decodePkg.sv
// Decode stage shared definitions
// Opcodes, word types, destination select and the control bundle
package decodePkg;

  typedef logic [15:0] wordT;  // Data and instruction word
  typedef logic [2:0] regSelT; // One of eight registers

  // Opcode field, instruction bits 15:11
  localparam logic [4:0] opHalt  = 5'b00000;
  localparam logic [4:0] opNop   = 5'b00001;
  localparam logic [4:0] opJal   = 5'b00110;
  localparam logic [4:0] opAddi  = 5'b01000;
  localparam logic [4:0] opAndni = 5'b01011;
  localparam logic [4:0] opBeqz  = 5'b01100;
  localparam logic [4:0] opSt    = 5'b10000;
  localparam logic [4:0] opLd    = 5'b10001;
  localparam logic [4:0] opAlu   = 5'b11011; // R-type, funct picks the op

  // Bubble, opcode only
  localparam wordT nopWord = {opNop, 11'b0};

  // Destination register source
  typedef enum logic [1:0] {
    rdRs   = 2'd0, // Bits 10:8
    rdRt   = 2'd1, // Bits 7:5
    rdRd   = 2'd2, // Bits 4:2
    rdLink = 2'd3  // Register 7
  } regDstT;

  // Control bundle handed to execute, memory and writeback
  typedef struct packed {
    logic [3:0] aluOp;
    logic [1:0] regSrc;  // Writeback source
    logic [1:0] bSrc;    // ALU B operand source
    logic       immSrc;  // Branch/jump offset, 0 imm8 and 1 imm11
    logic       regWrt;
    logic       memEn;
    logic       memWrt;
    logic       branch;
    logic       set;
    logic       sub;
    logic       invA;
    logic       invB;
    logic       aluJmp;
    logic       slbi;
    logic       halt;
    logic       btr;
    logic       jmp;
  } decodeCtrlT;

endpackage

//--- hazardUnit.sv
// Load-use hazard detection and branch flush control
// Flush runs FlushCycles cycles from a taken branch, frozen by stalls
`timescale 1ns/10ps
module hazardUnit #(
  parameter int unsigned FlushCycles = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall,
  input  logic              pcSrcX,
  input  logic              memRdEx,
  input  decodePkg::regSelT rtEx,
  input  decodePkg::regSelT readSel1,
  input  decodePkg::regSelT readSel2,
  output logic              hazard,
  output logic              flush
);

  typedef enum logic {
    stIdle,
    stFlushing
  } flushStateT;

  // Cycles left after the one that sees pcSrcX
  localparam logic [1:0] ReloadCnt = 2'(FlushCycles - 1);

  flushStateT state;
  logic [1:0] flushCnt;
  logic       loadUse;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= stIdle;
      flushCnt <= '0;
    end else if (!stall) begin
      if (pcSrcX) begin
        flushCnt <= ReloadCnt;
        state    <= (ReloadCnt != 2'd0) ? stFlushing : stIdle;
      end else if (state == stFlushing) begin
        flushCnt <= flushCnt - 2'd1;
        if (flushCnt == 2'd1) begin
          state <= stIdle; // Last flush cycle
        end
      end
    end
  end

  assign flush = pcSrcX || (state == stFlushing);

  // Load in execute writes a register this instruction reads
  assign loadUse = memRdEx && ((rtEx == readSel1) || (rtEx == readSel2));

  assign hazard = loadUse && (state == stIdle) && !pcSrcX;

  hazardFlushExclusive: assert property (
    @(posedge clk) disable iff (rst)
    !(hazard && flush)
  ) else $error("hazard and flush high together");

endmodule

//--- issueLatch.sv
// Issue latch in front of the decoder
// Inserts bubbles and replays the held instruction after a load-use stall
`timescale 1ns/10ps
module issueLatch (
  input  logic            clk,
  input  logic            rst,
  input  decodePkg::wordT instrIn,
  input  logic            hazard,
  input  logic            flush,
  input  logic            dataStall,
  output decodePkg::wordT instr
);

  decodePkg::wordT heldInstr;
  logic            prevHazard;
  logic            replay;

  always_ff @(posedge clk) begin
    if (rst) begin
      heldInstr  <= decodePkg::nopWord;
      prevHazard <= 1'b0;
    end else if (!dataStall) begin // Frozen while memory stalls
      heldInstr  <= instrIn;
      prevHazard <= hazard;
    end
  end

  // A held bubble is never replayed
  assign replay = prevHazard && (heldInstr != decodePkg::nopWord);

  always_comb begin
    if (hazard || flush || dataStall) begin
      instr = decodePkg::nopWord;
    end else if (replay) begin
      instr = heldInstr;
    end else begin
      instr = instrIn;
    end
  end

  flushGivesNop: assert property (
    @(posedge clk) disable iff (rst)
    flush |-> instr == decodePkg::nopWord
  ) else $error("Instruction %h issued during flush", instr);

  // The instruction stopped by a hazard issues in the next free cycle
  replayHeld: assert property (
    @(posedge clk) disable iff (rst)
    (hazard && !dataStall) ##1 !(hazard || flush || dataStall)
    |-> instr == $past(instrIn) || $past(instrIn) == decodePkg::nopWord
  ) else $error("Replay issued %h, expected %h", instr, $past(instrIn));

endmodule

//--- instrDecoder.sv
// Instruction decoder
// Opcode to control bundle, immediate extension and destination select
`timescale 1ns/10ps
module instrDecoder (
  input  decodePkg::wordT       instr,
  output decodePkg::decodeCtrlT ctrl,
  output decodePkg::regSelT     writeRegSel,
  output decodePkg::wordT       imm5Ext,
  output decodePkg::wordT       imm8Ext,
  output decodePkg::wordT       imm11Ext,
  output logic [1:0]            functOut,
  output logic [1:0]            brchCndSel
);

  // ALU op codes seen by execute
  localparam logic [3:0] aluAdd   = 4'h0;
  localparam logic [3:0] aluAnd   = 4'h3;
  localparam logic [3:0] aluPassA = 4'h7;
  localparam logic [3:0] aluFunct = 4'hf; // Execute decodes funct bits

  // Writeback source
  localparam logic [1:0] wbLink = 2'b00; // PC + 2
  localparam logic [1:0] wbMem  = 2'b01;
  localparam logic [1:0] wbAlu  = 2'b10;

  // ALU B operand source
  localparam logic [1:0] bReg  = 2'b00;
  localparam logic [1:0] bImm5 = 2'b01;
  localparam logic [1:0] bImm8 = 2'b10;

  logic [4:0]        opcode;
  decodePkg::regDstT regDst;
  logic              zeroExt;

  assign opcode = instr[15:11];

  always_comb begin
    ctrl    = '0;            // Unknown opcodes behave as NOP
    regDst  = decodePkg::rdRs;
    zeroExt = 1'b0;
    case (opcode)
      decodePkg::opHalt: begin
        ctrl.halt = 1'b1;
      end
      decodePkg::opAddi: begin
        ctrl.aluOp  = aluAdd;
        ctrl.bSrc   = bImm5;
        ctrl.regSrc = wbAlu;
        ctrl.regWrt = 1'b1;
        regDst      = decodePkg::rdRt;
      end
      decodePkg::opAndni: begin
        ctrl.aluOp  = aluAnd;
        ctrl.bSrc   = bImm5;
        ctrl.invB   = 1'b1;  // AND with inverted immediate
        ctrl.regSrc = wbAlu;
        ctrl.regWrt = 1'b1;
        regDst      = decodePkg::rdRt;
        zeroExt     = 1'b1;
      end
      decodePkg::opLd: begin
        ctrl.aluOp  = aluAdd; // Base plus offset
        ctrl.bSrc   = bImm5;
        ctrl.memEn  = 1'b1;
        ctrl.regSrc = wbMem;
        ctrl.regWrt = 1'b1;
        regDst      = decodePkg::rdRt;
      end
      decodePkg::opSt: begin
        ctrl.aluOp  = aluAdd;
        ctrl.bSrc   = bImm5;
        ctrl.memEn  = 1'b1;
        ctrl.memWrt = 1'b1;
        regDst      = decodePkg::rdRt;
      end
      decodePkg::opBeqz: begin
        ctrl.aluOp  = aluPassA; // Condition checked on Rs
        ctrl.bSrc   = bImm8;
        ctrl.branch = 1'b1;
        ctrl.immSrc = 1'b0;
      end
      decodePkg::opJal: begin
        ctrl.jmp    = 1'b1;
        ctrl.immSrc = 1'b1;
        ctrl.regSrc = wbLink;
        ctrl.regWrt = 1'b1;
        regDst      = decodePkg::rdLink;
      end
      decodePkg::opAlu: begin
        ctrl.aluOp  = aluFunct;
        ctrl.bSrc   = bReg;
        ctrl.regSrc = wbAlu;
        ctrl.regWrt = 1'b1;
        regDst      = decodePkg::rdRd;
      end
      default: begin
      end
    endcase
  end

  assign imm5Ext  = zeroExt ? {11'b0, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
  assign imm8Ext  = zeroExt ? {8'b0, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};
  assign imm11Ext = {{5{instr[10]}}, instr[10:0]}; // Jump offsets are always signed

  always_comb begin
    case (regDst)
      decodePkg::rdRs: writeRegSel = instr[10:8];
      decodePkg::rdRt: writeRegSel = instr[7:5];
      decodePkg::rdRd: writeRegSel = instr[4:2];
      default:         writeRegSel = 3'd7; // Link register
    endcase
  end

  assign functOut   = instr[1:0];
  assign brchCndSel = instr[12:11];

  // A store must also enable the memory
  memWrtNeedsEn: assert final (!ctrl.memWrt || ctrl.memEn)
    else $error("memWrt without memEn for opcode %b", opcode);

endmodule

//--- regFileBypass.sv
// Eight-entry register file, two read ports and one write port
// A read of the register being written returns the write data
`timescale 1ns/10ps
module regFileBypass (
  input  logic              clk,
  input  logic              rst,
  input  decodePkg::regSelT read1Sel,
  input  decodePkg::regSelT read2Sel,
  input  decodePkg::regSelT writeSel,
  input  decodePkg::wordT   writeData,
  input  logic              writeEn,
  output decodePkg::wordT   read1Data,
  output decodePkg::wordT   read2Data
);

  decodePkg::wordT regs [8];
  logic            bypass1;
  logic            bypass2;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[writeSel] <= writeData;
    end
  end

  // Same-cycle writeback forwarding
  assign bypass1 = writeEn && (read1Sel == writeSel);
  assign bypass2 = writeEn && (read2Sel == writeSel);

  assign read1Data = bypass1 ? writeData : regs[read1Sel];
  assign read2Data = bypass2 ? writeData : regs[read2Sel];

  // A written value is visible on the next cycle's read
  writeThenRead: assert property (
    @(posedge clk) disable iff (rst)
    writeEn ##1 (read1Sel == $past(writeSel)) && !bypass1
    |-> read1Data == $past(writeData)
  ) else $error("Port 1 read %h, expected %h", read1Data, $past(writeData));

endmodule

//--- decodeStage.sv
// Decode stage of the five-stage pipeline
// Issue latch, decoder, register file and hazard control
`timescale 1ns/10ps
module decodeStage #(
  parameter int unsigned FlushCycles = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  dataStall,
  input  logic                  instrStall,
  input  decodePkg::wordT       instrIn,
  input  logic                  regWriteWb,
  input  decodePkg::regSelT     writeRegSelWb,
  input  decodePkg::wordT       writeDataWb,
  input  logic                  pcSrcX,     // Branch taken in execute
  input  logic                  memRdEx,    // Load in execute
  input  decodePkg::regSelT     rtEx,
  output decodePkg::wordT       readData1,
  output decodePkg::wordT       readData2,
  output decodePkg::wordT       imm5Ext,
  output decodePkg::wordT       imm8Ext,
  output decodePkg::wordT       imm11Ext,
  output decodePkg::decodeCtrlT ctrl,
  output logic [1:0]            functOut,
  output logic [1:0]            brchCndSel,
  output decodePkg::regSelT     rs,
  output decodePkg::regSelT     rt,
  output decodePkg::regSelT     writeRegSel,
  output logic                  hazard,
  output logic                  flush,
  output decodePkg::wordT       instrOut
);

  decodePkg::wordT instr; // Instruction after bubble insertion

  assign rs       = instr[10:8];
  assign rt       = instr[7:5];
  assign instrOut = instr;

  issueLatch latch (
    .clk       (clk),
    .rst       (rst),
    .instrIn   (instrIn),
    .hazard    (hazard),
    .flush     (flush),
    .dataStall (dataStall),
    .instr     (instr)
  );

  instrDecoder decoder (
    .instr       (instr),
    .ctrl        (ctrl),
    .writeRegSel (writeRegSel),
    .imm5Ext     (imm5Ext),
    .imm8Ext     (imm8Ext),
    .imm11Ext    (imm11Ext),
    .functOut    (functOut),
    .brchCndSel  (brchCndSel)
  );

  regFileBypass regFile (
    .clk       (clk),
    .rst       (rst),
    .read1Sel  (rs),
    .read2Sel  (rt),
    .writeSel  (writeRegSelWb),
    .writeData (writeDataWb),
    .writeEn   (regWriteWb),
    .read1Data (readData1),
    .read2Data (readData2)
  );

  // Compares against the raw fetch word, not the bubbled one
  hazardUnit #(
    .FlushCycles (FlushCycles)
  ) hazardCtl (
    .clk      (clk),
    .rst      (rst),
    .stall    (dataStall | instrStall),
    .pcSrcX   (pcSrcX),
    .memRdEx  (memRdEx),
    .rtEx     (rtEx),
    .readSel1 (instrIn[10:8]),
    .readSel2 (instrIn[7:5]),
    .hazard   (hazard),
    .flush    (flush)
  );

endmodule

//--- tbDecodeStage.sv
// Testbench for the decode stage
// Models fetch, execute and writeback as port stimulus, checks with assertions
`timescale 1ns/10ps
module tbDecodeStage;

  localparam int FlushCycles = 2;
  localparam int TotalLen = 4 + 4 + 20 + 22 + 16 + 2 * (FlushCycles + 2) + FlushCycles + 8;
  localparam int TimeoutCycles = TotalLen * 3 / 2;

  logic clk = 1'b0;
  logic rst, dataStall, instrStall, regWriteWb, pcSrcX, memRdEx;
  decodePkg::wordT       instrIn, writeDataWb;
  decodePkg::regSelT     writeRegSelWb, rtEx;
  decodePkg::wordT       readData1, readData2, imm5Ext, imm8Ext, imm11Ext, instrOut;
  decodePkg::decodeCtrlT ctrl;
  logic [1:0]            functOut, brchCndSel;
  decodePkg::regSelT     rs, rt, writeRegSel;
  logic                  hazard, flush;

  // Check enables and expected values, driven alongside the stimulus
  logic chkRead, chkDecode, chkWrSel, chkFlow;
  decodePkg::wordT       expRead1, expRead2, expImm5, expImm8, expImm11, expInstr;
  decodePkg::decodeCtrlT expCtrl;
  decodePkg::regSelT     expWrSel, expRs, expRt;
  logic [1:0]            expFunct, expBrch;
  logic                  expHazard, expFlush;

  string       testName;
  int          errorCount = 0;
  int          testStartErrors, testsRun = 0, testsFailed = 0, cycleCount = 0;
  logic [31:0] lfsr = 32'hb08e;

  decodeStage #(.FlushCycles(FlushCycles)) dut (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycleCount);
      $display("Errors found");
      $finish;
    end
  end

  task automatic valueError(input string what, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    errorCount++;
    $display("** Error %s %s: expected %h, actual %h", testName, what, expVal, actVal);
  endtask

  read1Check: assert property (@(posedge clk) disable iff (rst)
    chkRead |-> readData1 == expRead1)
    else valueError("readData1", $sampled(expRead1), $sampled(readData1));
  read2Check: assert property (@(posedge clk) disable iff (rst)
    chkRead |-> readData2 == expRead2)
    else valueError("readData2", $sampled(expRead2), $sampled(readData2));
  ctrlCheck: assert property (@(posedge clk) disable iff (rst)
    chkDecode |-> ctrl == expCtrl)
    else valueError("ctrl", $sampled(expCtrl), $sampled(ctrl));
  imm5Check: assert property (@(posedge clk) disable iff (rst)
    chkDecode |-> imm5Ext == expImm5)
    else valueError("imm5Ext", $sampled(expImm5), $sampled(imm5Ext));
  imm8Check: assert property (@(posedge clk) disable iff (rst)
    chkDecode |-> imm8Ext == expImm8)
    else valueError("imm8Ext", $sampled(expImm8), $sampled(imm8Ext));
  imm11Check: assert property (@(posedge clk) disable iff (rst)
    chkDecode |-> imm11Ext == expImm11)
    else valueError("imm11Ext", $sampled(expImm11), $sampled(imm11Ext));
  functCheck: assert property (@(posedge clk) disable iff (rst)
    chkDecode |-> functOut == expFunct)
    else valueError("functOut", $sampled(expFunct), $sampled(functOut));
  brchCheck: assert property (@(posedge clk) disable iff (rst)
    chkDecode |-> brchCndSel == expBrch)
    else valueError("brchCndSel", $sampled(expBrch), $sampled(brchCndSel));
  rsCheck: assert property (@(posedge clk) disable iff (rst)
    chkDecode |-> rs == expRs)
    else valueError("rs", $sampled(expRs), $sampled(rs));
  rtCheck: assert property (@(posedge clk) disable iff (rst)
    chkDecode |-> rt == expRt)
    else valueError("rt", $sampled(expRt), $sampled(rt));
  wrSelCheck: assert property (@(posedge clk) disable iff (rst)
    chkWrSel |-> writeRegSel == expWrSel)
    else valueError("writeRegSel", $sampled(expWrSel), $sampled(writeRegSel));
  instrCheck: assert property (@(posedge clk) disable iff (rst)
    chkFlow |-> instrOut == expInstr)
    else valueError("instrOut", $sampled(expInstr), $sampled(instrOut));
  hazardCheck: assert property (@(posedge clk) disable iff (rst)
    chkFlow |-> hazard == expHazard)
    else valueError("hazard", $sampled(expHazard), $sampled(hazard));
  flushCheck: assert property (@(posedge clk) disable iff (rst)
    chkFlow |-> flush == expFlush)
    else valueError("flush", $sampled(expFlush), $sampled(flush));

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [15:0] randBits(input int n);
    logic [15:0] v;
    v = '0;
    repeat (n) begin
      v    = {v[14:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
    return v;
  endfunction

  // Expected control bundle per opcode
  function automatic decodePkg::decodeCtrlT tableCtrl(input logic [4:0] op);
    decodePkg::decodeCtrlT c;
    c = '0;
    case (op)
      decodePkg::opHalt:  c.halt = 1'b1;
      decodePkg::opAddi:  c = '{aluOp: 4'h0, bSrc: 2'd1, regSrc: 2'd2, regWrt: 1'b1, default: '0};
      decodePkg::opAndni: c = '{aluOp: 4'h3, bSrc: 2'd1, regSrc: 2'd2, regWrt: 1'b1,
                                invB: 1'b1, default: '0};
      decodePkg::opLd:    c = '{bSrc: 2'd1, regSrc: 2'd1, regWrt: 1'b1, memEn: 1'b1, default: '0};
      decodePkg::opSt:    c = '{bSrc: 2'd1, memEn: 1'b1, memWrt: 1'b1, default: '0};
      decodePkg::opBeqz:  c = '{aluOp: 4'h7, bSrc: 2'd2, branch: 1'b1, default: '0};
      decodePkg::opJal:   c = '{jmp: 1'b1, immSrc: 1'b1, regWrt: 1'b1, default: '0};
      decodePkg::opAlu:   c = '{aluOp: 4'hf, regSrc: 2'd2, regWrt: 1'b1, default: '0};
      default:            c = '0;
    endcase
    return c;
  endfunction

  task automatic expectFlow(input decodePkg::wordT word, input logic hz, input logic fl);
    chkFlow   <= 1'b1;
    expInstr  <= word;
    expHazard <= hz;
    expFlush  <= fl;
  endtask

  task automatic startTest(input string name);
    testName        = name;
    testStartErrors = errorCount;
  endtask

  // Idle the ports and wait one cycle so the last check reports first
  task automatic finishTest();
    int testErrors;
    chkRead    <= 1'b0;
    chkDecode  <= 1'b0;
    chkWrSel   <= 1'b0;
    chkFlow    <= 1'b0;
    instrIn    <= decodePkg::nopWord;
    memRdEx    <= 1'b0;
    pcSrcX     <= 1'b0;
    dataStall  <= 1'b0;
    instrStall <= 1'b0;
    regWriteWb <= 1'b0;
    @(posedge clk);
    testErrors = errorCount - testStartErrors;
    testsRun++;
    if (testErrors != 0) testsFailed++;
    $display("Test %-8s finished with %0d errors", testName, testErrors);
  endtask

  task automatic checkReset();
    startTest("reset");
    instrIn  <= {decodePkg::opAlu, 3'(randBits(3)), 3'(randBits(3)), 5'b0};
    chkRead  <= 1'b1;
    expRead1 <= '0;
    expRead2 <= '0;
    chkFlow  <= 1'b0;
    @(posedge clk);
    expectFlow(instrIn, 1'b0, 1'b0); // Same word again, now checked
    @(posedge clk);
    finishTest();
  endtask

  task automatic decodeTable();
    logic [4:0]  ops [9];
    logic [10:0] low;
    logic        zext;
    ops = '{decodePkg::opHalt, decodePkg::opNop, decodePkg::opAddi, decodePkg::opAndni,
            decodePkg::opLd, decodePkg::opSt, decodePkg::opBeqz, decodePkg::opJal,
            decodePkg::opAlu};
    startTest("decode");
    for (int p = 0; p < 2; p++) begin
      foreach (ops[k]) begin
        low = 11'(randBits(11));
        if (p == 1) low = low | 11'h490; // Sign bits of imm5, imm8 and imm11
        zext = (ops[k] == decodePkg::opAndni);
        instrIn   <= {ops[k], low};
        expectFlow({ops[k], low}, 1'b0, 1'b0);
        chkDecode <= 1'b1;
        expCtrl   <= tableCtrl(ops[k]);
        expImm5   <= zext ? {11'b0, low[4:0]} : {{11{low[4]}}, low[4:0]};
        expImm8   <= zext ? {8'b0, low[7:0]} : {{8{low[7]}}, low[7:0]};
        expImm11  <= 16'($signed(low));
        expFunct  <= low[1:0];
        expBrch   <= ops[k][1:0];
        expRs     <= low[10:8];
        expRt     <= low[7:5];
        case (ops[k])
          decodePkg::opAddi, decodePkg::opAndni, decodePkg::opLd, decodePkg::opSt: begin
            chkWrSel <= 1'b1;
            expWrSel <= low[7:5]; // I-type writes rt
          end
          decodePkg::opAlu: begin
            chkWrSel <= 1'b1;
            expWrSel <= low[4:2];
          end
          decodePkg::opJal: begin
            chkWrSel <= 1'b1;
            expWrSel <= 3'd7;
          end
          default: chkWrSel <= 1'b0;
        endcase
        @(posedge clk);
      end
    end
    finishTest();
  endtask

  task automatic regFileRoundTrip();
    decodePkg::wordT   model [8];
    decodePkg::regSelT wSel, rSel1, rSel2;
    decodePkg::wordT   wData;
    foreach (model[i]) model[i] = '0;
    startTest("regfile");
    repeat (12) begin
      wSel  = 3'(randBits(3));
      rSel2 = 3'(randBits(3));
      wData = randBits(16);
      instrIn       <= {decodePkg::opAlu, wSel, rSel2, 5'b0};
      regWriteWb    <= 1'b1;
      writeRegSelWb <= wSel;
      writeDataWb   <= wData;
      chkRead       <= 1'b1;
      expRead1      <= wData; // Bypassed in the write cycle
      expRead2      <= (rSel2 == wSel) ? wData : model[rSel2];
      model[wSel] = wData;
      @(posedge clk);
    end
    // Start with the register written last
    for (int i = 0; i < 8; i++) begin
      rSel1 = wSel + 3'(i);
      instrIn    <= {decodePkg::opAlu, rSel1, 3'(7 - i), 5'b0};
      regWriteWb <= 1'b0;
      expRead1   <= model[rSel1];
      expRead2   <= model[7 - i];
      @(posedge clk);
    end
    finishTest();
  endtask

  task automatic loadUseReplay();
    decodePkg::wordT held, other;
    startTest("loaduse");
    for (int k = 0; k < 4; k++) begin
      held  = {decodePkg::opAddi, 11'(randBits(11))};
      other = {decodePkg::opAlu, 11'(randBits(11))};
      instrIn <= held;
      memRdEx <= 1'b1;
      rtEx    <= k[0] ? held[7:5] : held[10:8];
      expectFlow(decodePkg::nopWord, 1'b1, 1'b0);
      @(posedge clk);
      instrIn <= other; // Replay ignores the fetch word
      memRdEx <= 1'b0;
      expectFlow(held, 1'b0, 1'b0);
      @(posedge clk);
      expectFlow(other, 1'b0, 1'b0);
      @(posedge clk);
    end
    // A held bubble is not replayed
    instrIn <= decodePkg::nopWord;
    memRdEx <= 1'b1;
    rtEx    <= 3'd0;
    expectFlow(decodePkg::nopWord, 1'b1, 1'b0);
    @(posedge clk);
    instrIn <= other;
    memRdEx <= 1'b0;
    expectFlow(other, 1'b0, 1'b0);
    @(posedge clk);
    finishTest();
  endtask

  task automatic branchFlush();
    decodePkg::wordT word, next;
    startTest("flush");
    repeat (2) begin
      word = {decodePkg::opAddi, 11'(randBits(11))};
      next = {decodePkg::opAlu, 11'(randBits(11))};
      instrIn <= word;
      memRdEx <= 1'b1; // Load-use match held during the flush
      rtEx    <= word[10:8];
      for (int k = 0; k < FlushCycles; k++) begin
        pcSrcX <= (k == 0);
        expectFlow(decodePkg::nopWord, 1'b0, 1'b1);
        @(posedge clk);
      end
      instrIn <= next;
      memRdEx <= 1'b0;
      expectFlow(next, 1'b0, 1'b0);
      @(posedge clk);
    end
    finishTest();
  endtask

  task automatic stallDuringFlush();
    decodePkg::wordT word;
    startTest("stall");
    word = {decodePkg::opLd, 11'(randBits(11))};
    instrIn   <= word;
    dataStall <= 1'b1;
    expectFlow(decodePkg::nopWord, 1'b0, 1'b0);
    @(posedge clk);
    dataStall <= 1'b0;
    expectFlow(word, 1'b0, 1'b0);
    @(posedge clk);
    pcSrcX <= 1'b1; // First unstalled flush cycle
    expectFlow(decodePkg::nopWord, 1'b0, 1'b1);
    @(posedge clk);
    pcSrcX    <= 1'b0;
    dataStall <= 1'b1;
    @(posedge clk);
    dataStall  <= 1'b0;
    instrStall <= 1'b1;
    @(posedge clk);
    instrStall <= 1'b0;
    repeat (FlushCycles - 1) @(posedge clk);
    expectFlow(word, 1'b0, 1'b0);
    @(posedge clk);
    finishTest();
  endtask

  initial begin
    rst           = 1'b1;
    dataStall     = 1'b0;
    instrStall    = 1'b0;
    instrIn       = decodePkg::nopWord;
    regWriteWb    = 1'b0;
    writeRegSelWb = '0;
    writeDataWb   = '0;
    pcSrcX        = 1'b0;
    memRdEx       = 1'b0;
    rtEx          = '0;
    chkRead       = 1'b0;
    chkDecode     = 1'b0;
    chkWrSel      = 1'b0;
    chkFlow       = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    checkReset();
    decodeTable();
    regFileRoundTrip();
    loadUseReplay();
    branchFlush();
    stallDuringFlush();
    $display("Tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- verilog.f
decodePkg.sv
hazardUnit.sv
issueLatch.sv
instrDecoder.sv
regFileBypass.sv
decodeStage.sv
tbDecodeStage.sv
